//--- all.f
crc_ahb_pkg.sv
crc_cfg_pkg.sv
crc_cfg_if.sv
crc_buf_if.sv
host_interface.sv
crc_buffer.sv
crc_datapath.sv
crc_ahb.sv
tb_crc_ahb.sv

//--- crc_ahb.sv
`timescale 1ns/100ps

module crc_ahb
#(
	parameter int BUF_DEPTH = 2
)
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] HADDR,
	input  logic [31:0] HWDATA,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic        HSElx,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);
	import crc_cfg_pkg::*;

	// Byte stream between buffer and engine
	logic [7:0] byte_data;
	logic       byte_valid;
	logic       byte_ready;
	logic       busy;
	rev_in_t    rev_in;

	crc_buf_if buf_bus();
	crc_cfg_if cfg_bus();

	// AHB slave and register file front end
	host_interface host_interface_i
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSElx     (HSElx),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP),
		.buf_port  (buf_bus.host),
		.cfg_port  (cfg_bus.host),
		.rev_in    (rev_in)
	);

	// Word to byte splitter
	crc_buffer
	#(
		.BUF_DEPTH (BUF_DEPTH)
	)
	crc_buffer_i
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.buf_port   (buf_bus.fifo),
		.rev_in     (rev_in),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready),
		.busy       (busy)
	);

	// CRC engine
	crc_datapath crc_datapath_i
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.cfg_port   (cfg_bus.dp),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready),
		.busy       (busy)
	);

endmodule

//--- crc_ahb_pkg.sv
package crc_ahb_pkg;

	// AHB transfer types
	// Only NON_SEQ opens an access, SEQ and BUSY beats are ignored
	typedef enum logic [1:0]
	{
		IDLE    = 2'b00,
		BUSY    = 2'b01,
		NON_SEQ = 2'b10,
		SEQ     = 2'b11
	} htrans_t;

	// Transfer size on HSIZE
	typedef logic [2:0] hsize_t;
	localparam hsize_t SIZE_BYTE = 3'd0;
	localparam hsize_t SIZE_HALF = 3'd1;
	localparam hsize_t SIZE_WORD = 3'd2;

	// Slave response, this core always answers OKAY
	localparam logic RESP_OK = 1'b0;

	// One bus data word
	typedef logic [31:0] hdata_t;

	// Register word offset, HADDR[4:2]
	typedef logic [2:0] reg_addr_t;
	localparam reg_addr_t CRC_DR   = 3'h0;
	localparam reg_addr_t CRC_IDR  = 3'h1;
	localparam reg_addr_t CRC_CR   = 3'h2;
	localparam reg_addr_t CRC_INIT = 3'h4;
	localparam reg_addr_t CRC_POL  = 3'h5;

endpackage

//--- crc_ahb_tests.txt
# name op offset size pipe wdata expected
# op W or R, offset is the register word offset, size 0 byte 1 halfword 2 word
# pipe 1 issues the transfer with no idle gap, expected is checked on reads only
reset    R 5 2 0 00000000 04C11DB7
reset    R 4 2 0 00000000 FFFFFFFF
reset    R 2 2 0 00000000 00000000
reset    R 1 2 0 00000000 00000000
reset    R 0 2 0 00000000 FFFFFFFF
regs     W 1 2 0 123456A5 00000000
regs     R 1 2 0 00000000 000000A5
regs     W 5 2 0 1EDC6F41 00000000
regs     R 5 2 0 00000000 1EDC6F41
regs     W 4 2 0 5A5A5A5A 00000000
regs     R 4 2 0 00000000 5A5A5A5A
regs     W 2 2 0 000000F9 00000000
regs     R 2 2 0 00000000 000000F8
crc32    W 2 2 0 00000000 00000000
crc32    W 5 2 0 04C11DB7 00000000
crc32    W 4 2 0 FFFFFFFF 00000000
crc32    W 0 2 0 34333231 00000000
crc32    W 0 2 0 38373635 00000000
crc32    W 0 0 0 00000039 00000000
crc32    R 0 2 0 00000000 0376E6E7
b2b      W 2 2 0 00000001 00000000
b2b      W 0 2 1 34333231 00000000
b2b      W 0 2 1 38373635 00000000
b2b      W 0 0 1 00000039 00000000
b2b      R 0 2 1 00000000 0376E6E7
rev_out  W 2 2 0 00000080 00000000
rev_out  R 0 2 0 00000000 E7676EC0
rev_byte W 2 2 0 000000A1 00000000
rev_byte W 0 2 0 34333231 00000000
rev_byte W 0 2 0 38373635 00000000
rev_byte W 0 0 0 00000039 00000000
rev_byte R 0 2 0 00000000 340BC6D9
rev_word W 2 2 0 000000E1 00000000
rev_word W 0 2 0 31323334 00000000
rev_word W 0 2 0 35363738 00000000
rev_word W 0 0 0 39000000 00000000
rev_word R 0 2 0 00000000 340BC6D9
rev_half W 2 2 0 000000C8 00000000
rev_half W 5 2 0 00008005 00000000
rev_half W 4 2 0 00000000 00000000
rev_half W 0 1 0 00003132 00000000
rev_half W 0 1 0 00003334 00000000
rev_half W 0 1 0 00003536 00000000
rev_half W 0 1 0 00003738 00000000
rev_half W 0 0 0 00003900 00000000
rev_half R 0 2 0 00000000 0000BB3D
crc8     W 2 2 0 00000010 00000000
crc8     W 5 2 0 00000007 00000000
crc8     W 4 2 0 00000000 00000000
crc8     W 0 2 0 34333231 00000000
crc8     W 0 1 0 00003635 00000000
crc8     W 0 1 0 00003837 00000000
crc8     W 0 0 0 00000039 00000000
crc8     R 0 2 0 00000000 000000F4
crc7     W 2 2 0 00000018 00000000
crc7     W 5 2 0 00000009 00000000
crc7     W 4 2 0 00000000 00000000
crc7     W 0 2 0 34333231 00000000
crc7     W 0 2 0 38373635 00000000
crc7     W 0 0 0 00000039 00000000
crc7     R 0 2 0 00000000 00000075

//--- crc_buf_if.sv
`timescale 1ns/100ps

interface crc_buf_if;
	import crc_ahb_pkg::*;

	// DR write into the word buffer
	logic   wr_en;
	hdata_t wr_data;
	hsize_t wr_size;

	// No room for another word
	logic   full;

	modport host
	(
		output wr_en, wr_data, wr_size,
		input  full
	);

	modport fifo
	(
		input  wr_en, wr_data, wr_size,
		output full
	);

endinterface

//--- crc_buffer.sv
`timescale 1ns/100ps

module crc_buffer
#(
	parameter int BUF_DEPTH = 2
)
(
	input  logic                 HCLK,
	input  logic                 HRESETn,
	crc_buf_if.fifo              buf_port,
	input  crc_cfg_pkg::rev_in_t rev_in,
	output logic [7:0]           byte_data,
	output logic                 byte_valid,
	input  logic                 byte_ready,
	output logic                 busy
);
	import crc_ahb_pkg::*;
	import crc_cfg_pkg::*;

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int LVL_W = $clog2(BUF_DEPTH + 1);

	// Word storage, last byte lane kept next to each word
	crc_word_u        word_mem [BUF_DEPTH];
	logic [1:0]       last_mem [BUF_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LVL_W-1:0] level;
	logic [1:0]       byte_idx;
	crc_word_u        in_word;
	logic [1:0]       in_last;
	logic             byte_take;
	logic             pop;

	// Bit reversal at one of three spans
	function automatic hdata_t reverse_in(input hdata_t d, input rev_in_t mode);
		hdata_t     r;
		logic [4:0] k;
		for (int i = 0; i < 32; i++)
		begin
			k = 5'(i);
			case (mode)
				REV_NONE: r[i] = d[i];
				REV_BYTE: r[i] = d[{k[4:3], ~k[2:0]}];
				REV_HALF: r[i] = d[{k[4], ~k[3:0]}];
				REV_WORD: r[i] = d[~k];
			endcase
		end
		return r;
	endfunction

	////////////////////////////////////////
	// Enqueue side
	////////////////////////////////////////

	assign in_word.word = reverse_in(buf_port.wr_data, rev_in);

	// Byte count from transfer size, stored as last lane
	always_comb
	begin
		case (buf_port.wr_size)
			SIZE_BYTE: in_last = 2'd0;
			SIZE_HALF: in_last = 2'd1;
			SIZE_WORD: in_last = 2'd3;
			default:   in_last = 2'd3;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (buf_port.wr_en)
		begin
			word_mem[wr_ptr] <= in_word;
			last_mem[wr_ptr] <= in_last;
		end
	end

	////////////////////////////////////////
	// Byte output side
	////////////////////////////////////////

	// Head word walked from lane 0 upward
	assign byte_valid = (level != '0);
	assign byte_data  = word_mem[rd_ptr].bytes[byte_idx];
	assign byte_take  = byte_valid && byte_ready;
	assign pop        = byte_take && (byte_idx == last_mem[rd_ptr]);

	assign busy          = (level != '0);
	assign buf_port.full = (level == LVL_W'(BUF_DEPTH));

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			level    <= '0;
			byte_idx <= 2'd0;
		end
		else
		begin
			if (buf_port.wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Occupancy
			if (buf_port.wr_en && !pop)
				level <= level + 1'b1;
			else if (pop && !buf_port.wr_en)
				level <= level - 1'b1;
			// Lane counter restarts with each word
			if (pop)
				byte_idx <= 2'd0;
			else if (byte_take)
				byte_idx <= byte_idx + 2'd1;
		end
	end

endmodule

//--- crc_cfg_if.sv
`timescale 1ns/100ps

interface crc_cfg_if;
	import crc_ahb_pkg::*;
	import crc_cfg_pkg::*;

	// Configuration from the control register
	poly_size_t poly_size;
	logic       rev_out;

	// Register write strobes and shared write data
	logic       init_en;
	logic       idr_en;
	logic       poly_en;
	logic       reset_chain;
	hdata_t     wr_data;

	// Read-back values and stall requests from the engine
	hdata_t     crc_out;
	hdata_t     init_out;
	logic [7:0] idr_out;
	hdata_t     poly_out;
	logic       reset_pending;
	logic       read_wait;

	modport host
	(
		output poly_size, rev_out, init_en, idr_en, poly_en, reset_chain, wr_data,
		input  crc_out, init_out, idr_out, poly_out, reset_pending, read_wait
	);

	modport dp
	(
		input  poly_size, rev_out, init_en, idr_en, poly_en, reset_chain, wr_data,
		output crc_out, init_out, idr_out, poly_out, reset_pending, read_wait
	);

endinterface

//--- crc_cfg_pkg.sv
package crc_cfg_pkg;

	// Polynomial width select, CR[4:3]
	typedef enum logic [1:0]
	{
		POLY_32 = 2'd0,
		POLY_16 = 2'd1,
		POLY_8  = 2'd2,
		POLY_7  = 2'd3
	} poly_size_t;

	// Input bit reversal, CR[6:5]
	typedef enum logic [1:0]
	{
		REV_NONE = 2'd0,
		REV_BYTE = 2'd1,
		REV_HALF = 2'd2,
		REV_WORD = 2'd3
	} rev_in_t;

	// Register values after reset
	localparam logic [31:0] RESET_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POLY = 32'h04C1_1DB7;
	localparam logic [4:0]  RESET_CR   = 5'h00;

	// Data word, seen whole or as four byte lanes
	typedef union packed
	{
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} crc_word_u;

endpackage

//--- crc_datapath.sv
`timescale 1ns/100ps

module crc_datapath
(
	input  logic       HCLK,
	input  logic       HRESETn,
	crc_cfg_if.dp      cfg_port,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	output logic       byte_ready,
	input  logic       busy
);
	import crc_ahb_pkg::*;
	import crc_cfg_pkg::*;

	// Programmable registers
	hdata_t     poly_ff;
	hdata_t     init_ff;
	logic [7:0] idr_ff;
	hdata_t     crc_ff;

	// Input stage, one byte in flight
	logic [7:0] data_ff;
	logic       pend_ff;

	hdata_t     width_mask;
	logic [4:0] width_msb;
	hdata_t     crc_next;
	hdata_t     crc_masked;
	crc_word_u  crc_rev;
	logic       byte_take;

	// One byte, MSB first, eight shift-xor steps
	function automatic hdata_t fold_byte
	(
		input hdata_t     crc,
		input logic [7:0] data,
		input hdata_t     poly,
		input hdata_t     mask,
		input logic [4:0] msb
	);
		hdata_t c;
		logic   fb;
		c = crc;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[msb] ^ data[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Width select
	////////////////////////////////////////

	always_comb
	begin
		case (cfg_port.poly_size)
			POLY_32:
			begin
				width_msb  = 5'd31;
				width_mask = 32'hFFFF_FFFF;
			end
			POLY_16:
			begin
				width_msb  = 5'd15;
				width_mask = 32'h0000_FFFF;
			end
			POLY_8:
			begin
				width_msb  = 5'd7;
				width_mask = 32'h0000_00FF;
			end
			POLY_7:
			begin
				width_msb  = 5'd6;
				width_mask = 32'h0000_007F;
			end
		endcase
	end

	////////////////////////////////////////
	// Byte intake
	////////////////////////////////////////

	// Engine takes a byte every cycle
	assign byte_ready = 1'b1;
	assign byte_take  = byte_valid && byte_ready;

	always_ff @(posedge HCLK)
	begin
		if (byte_take)
			data_ff <= byte_data;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			pend_ff <= 1'b0;
		else
			pend_ff <= byte_take;
	end

	assign crc_next = fold_byte(crc_ff, data_ff, poly_ff, width_mask, width_msb);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_ff <= RESET_POLY;
			init_ff <= RESET_INIT;
			idr_ff  <= 8'h00;
		end
		else
		begin
			if (cfg_port.poly_en)
				poly_ff <= cfg_port.wr_data;
			if (cfg_port.init_en)
				init_ff <= cfg_port.wr_data;
			// IDR is a scratch byte
			if (cfg_port.idr_en)
				idr_ff <= cfg_port.wr_data[7:0];
		end
	end

	// CRC register
	// INIT write and chain reset both reload, otherwise fold pending byte
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_ff <= RESET_INIT;
		else if (cfg_port.init_en)
			crc_ff <= cfg_port.wr_data;
		else if (cfg_port.reset_chain)
			crc_ff <= init_ff;
		else if (pend_ff)
			crc_ff <= crc_next;
	end

	////////////////////////////////////////
	// Output and status
	////////////////////////////////////////

	assign crc_masked = crc_ff & width_mask;

	// Full word mirror, then slide down into the chosen width
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			crc_rev.word[i] = crc_masked[31 - i];
		crc_rev.word = crc_rev.word >> (5'd31 - width_msb);
	end

	assign cfg_port.crc_out  = cfg_port.rev_out ? crc_rev.word : crc_masked;
	assign cfg_port.init_out = init_ff;
	assign cfg_port.idr_out  = idr_ff;
	assign cfg_port.poly_out = poly_ff;

	// Bytes still stored or still being folded
	assign cfg_port.reset_pending = busy || pend_ff;
	assign cfg_port.read_wait     = busy || byte_valid || pend_ff;

endmodule

//--- host_interface.sv
`timescale 1ns/100ps

module host_interface
(
	input  logic                  HCLK,
	input  logic                  HRESETn,
	input  logic [31:0]           HADDR,
	input  crc_ahb_pkg::hdata_t   HWDATA,
	input  crc_ahb_pkg::hsize_t   HSIZE,
	input  logic [1:0]            HTRANS,
	input  logic                  HWRITE,
	input  logic                  HSElx,
	input  logic                  HREADY,
	output crc_ahb_pkg::hdata_t   HRDATA,
	output logic                  HREADYOUT,
	output logic                  HRESP,
	crc_buf_if.host               buf_port,
	crc_cfg_if.host               cfg_port,
	output crc_cfg_pkg::rev_in_t  rev_in
);
	import crc_ahb_pkg::*;
	import crc_cfg_pkg::*;

	// Address phase pipeline
	reg_addr_t  haddr_pp;
	hsize_t     hsize_pp;
	htrans_t    htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// Control register {rev_out, rev_in, poly_size}
	logic [4:0] cr_ff;

	logic       sample_bus;
	logic       access;
	logic       write_en;
	logic       read_en;
	logic       dr_wr;
	logic       dr_rd;
	logic       idr_wr;
	logic       cr_wr;
	logic       init_wr;
	logic       poly_wr;
	hdata_t     cr_rd;

	////////////////////////////////////////
	// Address phase capture
	////////////////////////////////////////

	// New address only when the previous data phase completes
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= htrans_t'(HTRANS);
		end
	end

	// Address, size and direction carry no reset
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE;
			hwrite_pp <= HWRITE;
		end
	end

	////////////////////////////////////////
	// Data phase decode
	////////////////////////////////////////

	assign access   = hselx_pp && (htrans_pp == NON_SEQ);
	assign write_en = access && hwrite_pp;
	assign read_en  = access && !hwrite_pp;

	// Per-register strobes
	assign dr_wr   = write_en && (haddr_pp == CRC_DR);
	assign dr_rd   = read_en && (haddr_pp == CRC_DR);
	assign idr_wr  = write_en && (haddr_pp == CRC_IDR);
	assign cr_wr   = write_en && (haddr_pp == CRC_CR);
	assign init_wr = write_en && (haddr_pp == CRC_INIT);
	assign poly_wr = write_en && (haddr_pp == CRC_POL);

	// Wait states
	// DR write waits for buffer room, DR read for the engine to drain
	// INIT write waits until no byte is left to fold
	assign HREADYOUT = !((dr_wr && buf_port.full) ||
	                     (dr_rd && cfg_port.read_wait) ||
	                     (init_wr && cfg_port.reset_pending));

	assign HRESP = RESP_OK;

	// Buffer write side, data bus is taken live in the data phase
	assign buf_port.wr_en   = dr_wr && !buf_port.full;
	assign buf_port.wr_data = HWDATA;
	assign buf_port.wr_size = hsize_pp;

	// Engine register strobes
	assign cfg_port.wr_data = HWDATA;
	assign cfg_port.idr_en  = idr_wr;
	assign cfg_port.poly_en = poly_wr;
	assign cfg_port.init_en = init_wr && !cfg_port.reset_pending;

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_ff <= RESET_CR;
		else if (cr_wr)
			cr_ff <= HWDATA[7:3];
	end

	// Bit 0 is a one-shot reload, never stored
	assign cfg_port.reset_chain = cr_wr && HWDATA[0];

	assign cfg_port.poly_size = poly_size_t'(cr_ff[1:0]);
	assign rev_in             = rev_in_t'(cr_ff[3:2]);
	assign cfg_port.rev_out   = cr_ff[4];

	// CR reads back in its bus position, reset bit as zero
	assign cr_rd = {24'h0, cr_ff, 3'h0};

	////////////////////////////////////////
	// Read data
	////////////////////////////////////////

	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = cfg_port.crc_out;
			CRC_IDR:  HRDATA = {24'h0, cfg_port.idr_out};
			CRC_CR:   HRDATA = cr_rd;
			CRC_INIT: HRDATA = cfg_port.init_out;
			CRC_POL:  HRDATA = cfg_port.poly_out;
			default:  HRDATA = '0;
		endcase
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_crc_ahb -f all.f
out=$(./obj_dir/Vtb_crc_ahb)
echo "$out"
echo "$out" | grep -qx "TEST PASS"

//--- tb_crc_ahb.sv
`timescale 1ns/100ps

module tb_crc_ahb;

	localparam int CLK_HALF   = 4;
	localparam int WAIT_LIMIT = 200;

	logic        HCLK;
	logic        HRESETn;
	logic [31:0] HADDR;
	logic [31:0] HWDATA;
	logic [2:0]  HSIZE;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic        HSElx;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Transfer currently in its data phase
	logic        pend_valid;
	logic        pend_write;
	logic [31:0] pend_wdata;
	logic [31:0] pend_exp;
	string       pend_name;

	// Run bookkeeping
	int          err_count;
	int          test_err;
	int          check_count;
	int          tests_run;
	int          tests_failed;
	logic        aborted;
	logic [31:0] lcg_state;

	crc_ahb
	#(
		.BUF_DEPTH (2)
	)
	crc_ahb_i
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSElx     (HSElx),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	initial
	begin
		HCLK = 1'b0;
		forever
			#CLK_HALF HCLK = ~HCLK;
	end

	// Idle gap source
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	////////////////////////////////////////
	// AHB master
	////////////////////////////////////////

	// Drives one address phase on falling edges until the slave takes it
	// Outputs are sampled on the falling edge, they only move after a rising edge
	task automatic issue(input logic sel, input logic wr, input logic [2:0] off,
		input logic [2:0] size, input logic [31:0] wdata, input logic [31:0] exp,
		input string name);
		int          waited;
		logic        ready;
		logic [31:0] rdata;
		waited = 0;
		ready  = 1'b0;
		while (!ready && !aborted)
		begin
			@(negedge HCLK);
			ready  = HREADYOUT;
			rdata  = HRDATA;
			// Single slave, so the bus ready follows this slave
			HREADY = ready;
			HSElx  = sel;
			HTRANS = sel ? 2'b10 : 2'b00;
			HADDR  = {27'h0, off, 2'b00};
			HWRITE = wr;
			HSIZE  = size;
			// Write data belongs to the data phase still open
			HWDATA = (pend_valid && pend_write) ? pend_wdata : 32'h0;
			assert (HRESP === 1'b0)
			else
			begin
				$display("ERR %s HRESP: expected 0 actual %b", name, HRESP);
				test_err++;
			end
			if (ready)
			begin
				// Data phase ends on the next rising edge
				if (pend_valid && !pend_write)
				begin
					check_count++;
					assert (rdata === pend_exp)
					else
					begin
						$display("ERR %s HRDATA: expected %08h actual %08h",
							pend_name, pend_exp, rdata);
						test_err++;
					end
				end
			end
			else
			begin
				waited++;
				if (waited >= WAIT_LIMIT)
				begin
					$display("Timeout in test %s, HREADYOUT stayed low for %0d cycles",
						name, WAIT_LIMIT);
					aborted = 1'b1;
				end
			end
		end
		if (ready)
		begin
			pend_valid = sel;
			pend_write = wr;
			pend_wdata = wdata;
			pend_exp   = exp;
			pend_name  = name;
		end
	endtask

	task automatic idle_cycle(input string name);
		issue(1'b0, 1'b0, 3'd0, 3'd0, 32'h0, 32'h0, name);
	endtask

	// One line per finished test
	task automatic end_test(input string name, input int transfers);
		tests_run++;
		if (test_err == 0)
			$display("test %-10s %0d transfers, ok", name, transfers);
		else
		begin
			tests_failed++;
			$display("test %-10s %0d transfers, %0d errors", name, transfers, test_err);
		end
		err_count += test_err;
		test_err = 0;
	endtask

	////////////////////////////////////////
	// Test sequence from the data file
	////////////////////////////////////////

	initial
	begin
		int          fd;
		int          n;
		int          gap;
		int          transfers;
		string       line;
		string       name;
		string       op;
		string       cur_name;
		logic [2:0]  off;
		logic [2:0]  size;
		logic        pipe;
		logic [31:0] data;
		logic [31:0] exp;

		HRESETn      = 1'b0;
		HADDR        = 32'h0;
		HWDATA       = 32'h0;
		HSIZE        = 3'd0;
		HTRANS       = 2'b00;
		HWRITE       = 1'b0;
		HSElx        = 1'b0;
		HREADY       = 1'b1;
		pend_valid   = 1'b0;
		pend_write   = 1'b0;
		pend_wdata   = 32'h0;
		pend_exp     = 32'h0;
		pend_name    = "";
		err_count    = 0;
		test_err     = 0;
		check_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		aborted      = 1'b0;
		lcg_state    = 32'd59;
		transfers    = 0;
		cur_name     = "";

		// Three clocks of reset, released away from the rising edge
		repeat (3)
			@(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;

		fd = $fopen("crc_ahb_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the test file crc_ahb_tests.txt");
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && !$feof(fd))
		begin
			n = $fgets(line, fd);
			// Skip blank and comment lines
			if (n > 0 && line.len() > 1 && line[0] != "#")
			begin
				n = $sscanf(line, "%s %s %h %h %h %h %h",
					name, op, off, size, pipe, data, exp);
				if (n != 7 || (op != "W" && op != "R"))
				begin
					$display("Malformed line in the test file: %s", line);
					err_count++;
				end
				else
				begin
					// New name, so close the last test after its data phase
					if (name != cur_name)
					begin
						if (cur_name != "")
						begin
							idle_cycle(cur_name);
							end_test(cur_name, transfers);
						end
						cur_name  = name;
						transfers = 0;
					end
					if (!pipe)
					begin
						lcg_state = lcg_next(lcg_state);
						gap = int'((lcg_state >> 16) % 32'd4);
						repeat (gap)
							idle_cycle(name);
					end
					issue(1'b1, op == "W", off, size, data, exp, name);
					transfers++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		// Last data phase
		idle_cycle(cur_name);
		if (cur_name != "")
			end_test(cur_name, transfers);

		$display("tests %0d, passed %0d, failed %0d, read checks %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, check_count, err_count);
		if (!aborted && err_count == 0 && tests_run > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
